/* common/spmd_pkg.sv */
`default_nettype none

// ------------------------------------------------------------
// mesh network packet fields
// ------------------------------------------------------------
package spmd_pkg;

  localparam int addr_width = 30;  // word address inside a tile
  localparam int data_width = 32;
  localparam int cord_width = 4;   // x and y tile coordinates

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [cord_width-1:0] cord_t;

  // every packet is a remote store with all four bytes enabled,
  // so opcode and byte mask never travel on a port

endpackage

`default_nettype wire

/* common/loader_pkg.sv */
`default_nettype none

// ------------------------------------------------------------
// loader phases and tile address map
// ------------------------------------------------------------
package loader_pkg;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_CONFIG,     // group origin registers
    PH_ICACHE,     // instruction cache image
    PH_DMEM,       // data memory image
    PH_UNFREEZE,   // release the tiles
    PH_DONE
  } phase_e;

  // tile byte address space, config space begins at its top bit
  localparam int epa_byte_addr_width = 16;
  localparam int config_byte_addr    = 1 << (epa_byte_addr_width - 1);

  // byte offsets inside config space
  localparam int csr_org_x = 4;
  localparam int csr_org_y = 8;

  // icache window flag lands on word address bit (icache_mask_bits - 2)
  localparam int icache_mask_bits = 12;

  localparam int idx_width = 16;  // per tile word counter

endpackage

`default_nettype wire

/* common/load_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one load request, phase controller to image fetch
interface load_req_if;
  import spmd_pkg::*;
  import loader_pkg::*;

  logic                 valid;
  logic                 ready;
  phase_e               phase;
  cord_t                x;      // target tile
  cord_t                y;
  logic [idx_width-1:0] idx;    // word index within the tile

  modport ctrl  (output valid, phase, x, y, idx, input ready);
  modport fetch (input valid, phase, x, y, idx, output ready);

endinterface

`default_nettype wire

/* common/load_word_if.sv */
`timescale 1ns/1ps
`default_nettype none

// fetched word plus its target, image fetch to packet former
interface load_word_if;
  import spmd_pkg::*;
  import loader_pkg::*;

  logic                 valid;
  logic                 ready;
  phase_e               phase;
  cord_t                x;
  cord_t                y;
  logic [idx_width-1:0] idx;
  data_t                word;   // image word, unused in config and unfreeze

  modport fetch  (output valid, phase, x, y, idx, word, input ready);
  modport former (input valid, phase, x, y, idx, word, output ready);

endinterface

`default_nettype wire

/* loader/spmd_phase_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spmd_phase_ctrl #(
  parameter int tg_org_x_p       = 1,
  parameter int tg_org_y_p       = 1,
  parameter int tg_dim_x_p       = 2,
  parameter int tg_dim_y_p       = 2,
  parameter int icache_entries_p = 16,
  parameter int dmem_words_p     = 8
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  load_req_if.ctrl req,
  input  logic     last_sent_i,   // final unfreeze packet left the former
  output logic     done_o
);
  import spmd_pkg::*;
  import loader_pkg::*;

  localparam cord_t org_x  = cord_t'(tg_org_x_p);
  localparam cord_t org_y  = cord_t'(tg_org_y_p);
  localparam cord_t last_x = cord_t'(tg_org_x_p + tg_dim_x_p - 1);
  localparam cord_t last_y = cord_t'(tg_org_y_p + tg_dim_y_p - 1);

  phase_e               phase_q;
  phase_e               phase_nxt;
  cord_t                x_q;
  cord_t                y_q;
  logic [idx_width-1:0] idx_q;
  logic [idx_width-1:0] idx_last;
  logic                 xfer;
  logic                 tile_done;
  logic                 group_done;
  logic                 done_q;

  // ----------------------------------------------------------
  // per phase word count and phase order
  // ----------------------------------------------------------
  always_comb begin
    case (phase_q)
      PH_CONFIG: idx_last = idx_width'(1);                   // org x, org y
      PH_ICACHE: idx_last = idx_width'(icache_entries_p - 1);
      PH_DMEM:   idx_last = idx_width'(dmem_words_p - 1);
      default:   idx_last = '0;                              // one unfreeze store
    endcase
  end

  always_comb begin
    case (phase_q)
      PH_IDLE:     phase_nxt = PH_CONFIG;
      PH_CONFIG:   phase_nxt = PH_ICACHE;
      PH_ICACHE:   phase_nxt = PH_DMEM;
      PH_DMEM:     phase_nxt = PH_UNFREEZE;
      default:     phase_nxt = PH_DONE;
    endcase
  end

  assign xfer       = req.valid && req.ready;
  assign tile_done  = xfer && (idx_q == idx_last);
  assign group_done = tile_done && (x_q == last_x) && (y_q == last_y);

  // ----------------------------------------------------------
  // phase register and tile/word walk
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= PH_IDLE;
      x_q     <= org_x;
      y_q     <= org_y;
      idx_q   <= '0;
    end else begin
      if (phase_q == PH_IDLE || group_done) begin
        phase_q <= phase_nxt;
      end
      if (xfer) begin
        if (!tile_done) begin
          idx_q <= idx_q + 1'b1;
        end else begin
          idx_q <= '0;
          if (x_q != last_x) begin
            x_q <= x_q + 1'b1;
          end else begin
            x_q <= org_x;                                  // next row
            y_q <= (y_q == last_y) ? org_y : y_q + 1'b1;   // wraps for next phase
          end
        end
      end
    end
  end

  // sticky until reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else if (last_sent_i && phase_q == PH_DONE) begin
      done_q <= 1'b1;
    end
  end

  assign req.valid = (phase_q != PH_IDLE) && (phase_q != PH_DONE);
  assign req.phase = phase_q;
  assign req.x     = x_q;
  assign req.y     = y_q;
  assign req.idx   = idx_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

/* loader/image_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module image_fetch #(
  parameter int img_dmem_word_p = 64
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  load_req_if.fetch       req,
  load_word_if.fetch      word,
  output logic            img_rd_o,
  output spmd_pkg::addr_t img_addr_o,
  input  spmd_pkg::data_t img_data_i   // valid the cycle after img_rd_o
);
  import spmd_pkg::*;
  import loader_pkg::*;

  logic                 accept;
  logic                 rd_phase;
  logic                 hold_v_q;   // one item held
  logic                 fresh_q;    // its word is on img_data_i right now
  phase_e               phase_q;
  cord_t                x_q;
  cord_t                y_q;
  logic [idx_width-1:0] idx_q;
  data_t                word_q;

  assign req.ready = !hold_v_q || word.ready;   // empty, or leaving this cycle
  assign accept    = req.valid && req.ready;
  assign rd_phase  = (req.phase == PH_ICACHE) || (req.phase == PH_DMEM);
  assign img_rd_o  = accept && rd_phase;

  always_comb begin
    case (req.phase)
      PH_DMEM: img_addr_o = addr_t'(img_dmem_word_p) + addr_t'(req.idx);
      default: img_addr_o = addr_t'(req.idx);   // icache code sits at word 0
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hold_v_q <= 1'b0;
      fresh_q  <= 1'b0;
    end else begin
      if (accept) begin
        hold_v_q <= 1'b1;
      end else if (word.ready) begin
        hold_v_q <= 1'b0;
      end
      fresh_q <= img_rd_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      phase_q <= req.phase;
      x_q     <= req.x;
      y_q     <= req.y;
      idx_q   <= req.idx;
    end
    if (fresh_q) begin
      word_q <= img_data_i;   // keep it in case the former stalls
    end
  end

  assign word.valid = hold_v_q;
  assign word.phase = phase_q;
  assign word.x     = x_q;
  assign word.y     = y_q;
  assign word.idx   = idx_q;
  assign word.word  = fresh_q ? img_data_i : word_q;

endmodule

`default_nettype wire

/* loader/packet_former.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_former #(
  parameter int tg_org_x_p       = 1,
  parameter int tg_org_y_p       = 1,
  parameter int tg_dim_x_p       = 2,
  parameter int tg_dim_y_p       = 2,
  parameter int dmem_base_word_p = 256
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  load_word_if.former     word,
  input  spmd_pkg::cord_t my_x_i,
  input  spmd_pkg::cord_t my_y_i,
  output spmd_pkg::addr_t pkt_addr_o,
  output spmd_pkg::data_t pkt_data_o,
  output spmd_pkg::cord_t pkt_x_o,
  output spmd_pkg::cord_t pkt_y_o,
  output spmd_pkg::cord_t pkt_src_x_o,
  output spmd_pkg::cord_t pkt_src_y_o,
  output logic            v_o,
  input  logic            ready_i,
  output logic            last_sent_o
);
  import spmd_pkg::*;
  import loader_pkg::*;

  // word addresses of the config registers
  localparam addr_t cfg_word_addr = addr_t'(config_byte_addr >> 2);
  localparam addr_t org_x_word    = addr_t'((config_byte_addr | csr_org_x) >> 2);
  localparam addr_t org_y_word    = addr_t'((config_byte_addr | csr_org_y) >> 2);
  localparam addr_t icache_flag   = addr_t'(1) << (icache_mask_bits - 2);
  localparam cord_t last_x        = cord_t'(tg_org_x_p + tg_dim_x_p - 1);
  localparam cord_t last_y        = cord_t'(tg_org_y_p + tg_dim_y_p - 1);

  logic  accept;
  logic  enc_last;
  addr_t enc_addr;
  data_t enc_data;
  logic  v_q;
  logic  last_q;   // held packet is the final unfreeze

  // ----------------------------------------------------------
  // address and payload per phase
  // ----------------------------------------------------------
  always_comb begin
    case (word.phase)
      PH_CONFIG: begin
        enc_addr = word.idx[0] ? org_y_word : org_x_word;
        enc_data = word.idx[0] ? data_t'(tg_org_y_p) : data_t'(tg_org_x_p);
      end
      PH_ICACHE: begin
        enc_addr = icache_flag | addr_t'(word.idx);
        enc_data = word.word;
      end
      PH_DMEM: begin
        enc_addr = addr_t'(dmem_base_word_p) + addr_t'(word.idx);
        enc_data = word.word;
      end
      default: begin
        enc_addr = cfg_word_addr;   // unfreeze, store zero to config base
        enc_data = '0;
      end
    endcase
  end

  assign enc_last   = (word.phase == PH_UNFREEZE) && (word.x == last_x) && (word.y == last_y);
  assign word.ready = !v_q || ready_i;
  assign accept     = word.valid && word.ready;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      v_q    <= 1'b0;
      last_q <= 1'b0;
    end else if (accept) begin
      v_q    <= 1'b1;
      last_q <= enc_last;
    end else if (ready_i) begin
      v_q    <= 1'b0;   // packet went out, nothing behind it
      last_q <= 1'b0;
    end
  end

  // packet fields only move on accept, so they hold under stall
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pkt_addr_o  <= enc_addr;
      pkt_data_o  <= enc_data;
      pkt_x_o     <= word.x;
      pkt_y_o     <= word.y;
      pkt_src_x_o <= my_x_i;
      pkt_src_y_o <= my_y_i;
    end
  end

  assign v_o         = v_q;
  assign last_sent_o = v_q && ready_i && last_q;

endmodule

`default_nettype wire

/* verilog/spmd_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module spmd_loader #(
  parameter int tg_org_x_p       = 1,
  parameter int tg_org_y_p       = 1,
  parameter int tg_dim_x_p       = 2,
  parameter int tg_dim_y_p       = 2,
  parameter int icache_entries_p = 16,
  parameter int dmem_words_p     = 8,
  parameter int dmem_base_word_p = 256,
  parameter int img_dmem_word_p  = 64
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  // remote store packet out
  output spmd_pkg::addr_t pkt_addr_o,
  output spmd_pkg::data_t pkt_data_o,
  output spmd_pkg::cord_t pkt_x_o,
  output spmd_pkg::cord_t pkt_y_o,
  output spmd_pkg::cord_t pkt_src_x_o,
  output spmd_pkg::cord_t pkt_src_y_o,
  output logic            v_o,
  input  logic            ready_i,
  input  spmd_pkg::cord_t my_x_i,
  input  spmd_pkg::cord_t my_y_i,
  // program image read port
  output logic            img_rd_o,
  output spmd_pkg::addr_t img_addr_o,
  input  spmd_pkg::data_t img_data_i,
  output logic            done_o
);

  logic last_sent;

  load_req_if  req_if ();
  load_word_if word_if ();

  spmd_phase_ctrl #(
    .tg_org_x_p       (tg_org_x_p),
    .tg_org_y_p       (tg_org_y_p),
    .tg_dim_x_p       (tg_dim_x_p),
    .tg_dim_y_p       (tg_dim_y_p),
    .icache_entries_p (icache_entries_p),
    .dmem_words_p     (dmem_words_p)
  ) spmd_phase_ctrl_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req         (req_if.ctrl),
    .last_sent_i (last_sent),
    .done_o      (done_o)
  );

  image_fetch #(
    .img_dmem_word_p (img_dmem_word_p)
  ) image_fetch_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req        (req_if.fetch),
    .word       (word_if.fetch),
    .img_rd_o   (img_rd_o),
    .img_addr_o (img_addr_o),
    .img_data_i (img_data_i)
  );

  packet_former #(
    .tg_org_x_p       (tg_org_x_p),
    .tg_org_y_p       (tg_org_y_p),
    .tg_dim_x_p       (tg_dim_x_p),
    .tg_dim_y_p       (tg_dim_y_p),
    .dmem_base_word_p (dmem_base_word_p)
  ) packet_former_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .word        (word_if.former),
    .my_x_i      (my_x_i),
    .my_y_i      (my_y_i),
    .pkt_addr_o  (pkt_addr_o),
    .pkt_data_o  (pkt_data_o),
    .pkt_x_o     (pkt_x_o),
    .pkt_y_o     (pkt_y_o),
    .pkt_src_x_o (pkt_src_x_o),
    .pkt_src_y_o (pkt_src_y_o),
    .v_o         (v_o),
    .ready_i     (ready_i),
    .last_sent_o (last_sent)
  );

endmodule

`default_nettype wire

/* testbench/loader_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module loader_chk (
  input logic            clk_i,
  input logic            rst_n_i,
  input logic            v_i,
  input logic            ready_i,
  input spmd_pkg::addr_t addr_i,
  input spmd_pkg::data_t data_i,
  input spmd_pkg::cord_t x_i,
  input spmd_pkg::cord_t y_i
);

  int assert_fails = 0;   // failures seen by the top at the end of the run

  // a stalled packet stays offered
  hold_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_i && !ready_i |=> v_i)
    else begin assert_fails++; $error("v_o dropped under stall"); end

  // and keeps its contents
  hold_fields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_i && !ready_i |=> $stable(addr_i) && $stable(data_i) && $stable(x_i) && $stable(y_i))
    else begin assert_fails++; $error("packet fields changed under stall"); end

  quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !v_i)
    else begin assert_fails++; $error("v_o high during reset"); end

endmodule

bind packet_former loader_chk loader_chk_inst (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .v_i     (v_o),
  .ready_i (ready_i),
  .addr_i  (pkt_addr_o),
  .data_i  (pkt_data_o),
  .x_i     (pkt_x_o),
  .y_i     (pkt_y_o)
);

`default_nettype wire

/* testbench/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int tg_org_x_p       = 1,
  parameter int tg_org_y_p       = 1,
  parameter int tg_dim_x_p       = 2,
  parameter int tg_dim_y_p       = 2,
  parameter int icache_entries_p = 16,
  parameter int dmem_words_p     = 8,
  parameter int dmem_base_word_p = 256,
  parameter int img_dmem_word_p  = 64,
  parameter int img_words_p      = 72
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  spmd_pkg::addr_t pkt_addr_i,
  input  spmd_pkg::data_t pkt_data_i,
  input  spmd_pkg::cord_t pkt_x_i,
  input  spmd_pkg::cord_t pkt_y_i,
  input  spmd_pkg::cord_t pkt_src_x_i,
  input  spmd_pkg::cord_t pkt_src_y_i,
  input  logic            v_i,
  input  logic            ready_i,
  input  logic            done_i,
  input  logic            img_rd_i,
  input  spmd_pkg::cord_t my_x_i,
  input  spmd_pkg::cord_t my_y_i,
  input  spmd_pkg::data_t image_i [img_words_p],
  output logic            finished_o,
  output int              errors_o
);
  import spmd_pkg::*;
  import loader_pkg::*;

  typedef struct packed {
    logic [2:0] test;   // test the packet counts toward
    addr_t      addr;
    data_t      data;
    cord_t      x;
    cord_t      y;
  } pkt_t;

  localparam int tiles    = tg_dim_x_p * tg_dim_y_p;
  localparam int n_config = tiles * 2;
  localparam int n_icache = tiles * icache_entries_p;
  localparam int n_dmem   = tiles * dmem_words_p;
  localparam int total    = n_config + n_icache + n_dmem + tiles;

  string names [6] = '{"reset", "config packets", "icache packets", "dmem packets",
                       "stall and count", "unfreeze and done"};
  int    checks [6];
  int    errs [6];
  int    seen;     // packets transferred so far
  logic  stalled;
  pkt_t  held;

  // ----------------------------------------------------------
  // expected packet at a position of the load order
  // ----------------------------------------------------------
  function automatic pkt_t expected_pkt(input int pos);
    pkt_t p;
    int   per_tile;
    int   local_pos;
    int   tile;
    int   idx;
    if (pos < n_config) begin
      p.test    = 3'd1;
      per_tile  = 2;
      local_pos = pos;
    end else if (pos < n_config + n_icache) begin
      p.test    = 3'd2;
      per_tile  = icache_entries_p;
      local_pos = pos - n_config;
    end else if (pos < n_config + n_icache + n_dmem) begin
      p.test    = 3'd3;
      per_tile  = dmem_words_p;
      local_pos = pos - n_config - n_icache;
    end else begin
      p.test    = 3'd5;
      per_tile  = 1;
      local_pos = pos - n_config - n_icache - n_dmem;
    end
    tile = local_pos / per_tile;
    idx  = local_pos % per_tile;
    p.x  = cord_t'(tg_org_x_p + tile % tg_dim_x_p);   // x walks fastest
    p.y  = cord_t'(tg_org_y_p + tile / tg_dim_x_p);
    case (p.test)
      3'd1: begin
        p.addr = addr_t'((config_byte_addr + (idx == 0 ? csr_org_x : csr_org_y)) / 4);
        p.data = data_t'(idx == 0 ? tg_org_x_p : tg_org_y_p);
      end
      3'd2: begin
        p.addr = addr_t'(idx + (1 << (icache_mask_bits - 2)));
        p.data = image_i[idx];
      end
      3'd3: begin
        p.addr = addr_t'(dmem_base_word_p + idx);
        p.data = image_i[img_dmem_word_p + idx];
      end
      default: begin
        p.addr = addr_t'(config_byte_addr / 4);   // unfreeze store
        p.data = '0;
      end
    endcase
    return p;
  endfunction

  task automatic check_field(input int t, input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks[t]++;
    if (got !== want) begin
      errs[t]++;
      $display("ERR %s at packet %0d: got 0x%0h, expected 0x%0h", name, seen, got, want);
    end
  endtask

  task automatic fail_note(input int t, input string what);
    errs[t]++;
    $display("error in %s: %s", names[t], what);
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %0d checks, %0d errors, %s", t, names[t], checks[t], errs[t],
             errs[t] == 0 ? "pass" : "fail");
  endtask

  // ----------------------------------------------------------
  // compare process sampled mid cycle
  // ----------------------------------------------------------
  initial begin : compare
    pkt_t want;
    int   wait_cycles;
    int   failed;
    int   reads;    // image reads seen on img_rd_o
    finished_o = 1'b0;
    errors_o   = 0;
    seen       = 0;
    reads      = 0;
    stalled    = 1'b0;
    @(negedge clk_i);
    while (!rst_n_i) begin
      check_field(0, "v_o", v_i, 1'b0);
      check_field(0, "done_o", done_i, 1'b0);
      @(negedge clk_i);
    end
    check_field(0, "v_o", v_i, 1'b0);   // first cycle out of reset
    check_field(0, "done_o", done_i, 1'b0);
    report_test(0);

    while (seen < total) begin
      @(negedge clk_i);
      if (img_rd_i) reads++;
      if (stalled) begin
        check_field(4, "v_o", v_i, 1'b1);
        check_field(4, "pkt_addr_o", pkt_addr_i, held.addr);
        check_field(4, "pkt_data_o", pkt_data_i, held.data);
        check_field(4, "pkt_x_o", pkt_x_i, held.x);
        check_field(4, "pkt_y_o", pkt_y_i, held.y);
      end
      check_field(5, "done_o", done_i, 1'b0);
      if (v_i && ready_i) begin
        want = expected_pkt(seen);
        check_field(want.test, "pkt_addr_o", pkt_addr_i, want.addr);
        check_field(want.test, "pkt_data_o", pkt_data_i, want.data);
        check_field(want.test, "pkt_x_o", pkt_x_i, want.x);
        check_field(want.test, "pkt_y_o", pkt_y_i, want.y);
        check_field(want.test, "pkt_src_x_o", pkt_src_x_i, my_x_i);
        check_field(want.test, "pkt_src_y_o", pkt_src_y_i, my_y_i);
        seen++;
        if (seen == n_config || seen == n_config + n_icache ||
            seen == n_config + n_icache + n_dmem) begin
          report_test(want.test);
        end
      end
      stalled = v_i && !ready_i;
      held    = {3'd0, pkt_addr_i, pkt_data_i, pkt_x_i, pkt_y_i};
    end

    // done must follow the last packet within a few cycles
    wait_cycles = 0;
    @(negedge clk_i);
    while (!done_i && wait_cycles < 8) begin
      wait_cycles++;
      @(negedge clk_i);
    end
    checks[5]++;
    if (!done_i) fail_note(5, "done_o did not rise after the last packet");
    repeat (16) begin
      checks[4]++;
      checks[5]++;
      if (img_rd_i) reads++;
      if (v_i) fail_note(4, $sformatf("packet beyond the expected %0d", total));
      if (!done_i) fail_note(5, "done_o fell before reset");
      @(negedge clk_i);
    end
    // one image read per icache and dmem word, none for config or unfreeze
    check_field(4, "img_rd_o reads", reads, n_icache + n_dmem);
    report_test(4);
    report_test(5);

    failed = 0;
    for (int t = 0; t < 6; t++) begin
      errors_o += errs[t];
      if (errs[t] != 0) failed++;
    end
    $display("summary: 6 tests, %0d failed, %0d packets, %0d errors", failed, seen, errors_o);
    finished_o = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import spmd_pkg::*;

  localparam int tg_org_x       = 1;
  localparam int tg_org_y       = 1;
  localparam int tg_dim_x       = 2;
  localparam int tg_dim_y       = 2;
  localparam int icache_n       = 16;
  localparam int dmem_n         = 8;
  localparam int dmem_base      = 256;
  localparam int img_dmem       = 64;
  localparam int img_words      = img_dmem + dmem_n;   // image covers code and data
  localparam int total_pkts     = tg_dim_x * tg_dim_y * (3 + icache_n + dmem_n);
  localparam int timeout_cycles = total_pkts * 8 + 200;

  logic        clk;
  logic        rst_n;
  logic        ready;
  logic        v;
  logic        done;
  logic        img_rd;
  addr_t       img_addr;
  data_t       img_data;
  addr_t       pkt_addr;
  data_t       pkt_data;
  cord_t       pkt_x;
  cord_t       pkt_y;
  cord_t       pkt_src_x;
  cord_t       pkt_src_y;
  cord_t       my_x;
  cord_t       my_y;
  logic [31:0] rng;
  data_t       image_mem [img_words];
  logic        chk_finished;
  int          chk_errors;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // image model and random ready driven 1 ns after the edge
  // ----------------------------------------------------------
  initial begin : image_and_ready
    logic  rd_seen;
    addr_t addr_seen;
    forever begin
      @(negedge clk);
      rd_seen   = img_rd;      // read request of this cycle
      addr_seen = img_addr;
      @(posedge clk);
      #1;
      if (rd_seen && addr_seen < img_words) begin
        img_data = image_mem[addr_seen];
      end else begin
        img_data = 32'hdead_beef;   // nothing requested
      end
      rng   = lcg_next(rng);
      ready = rng[31:30] != 2'b00;  // high about three cycles in four
    end
  end

  spmd_loader #(
    .tg_org_x_p       (tg_org_x),
    .tg_org_y_p       (tg_org_y),
    .tg_dim_x_p       (tg_dim_x),
    .tg_dim_y_p       (tg_dim_y),
    .icache_entries_p (icache_n),
    .dmem_words_p     (dmem_n),
    .dmem_base_word_p (dmem_base),
    .img_dmem_word_p  (img_dmem)
  ) spmd_loader_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .pkt_addr_o  (pkt_addr),
    .pkt_data_o  (pkt_data),
    .pkt_x_o     (pkt_x),
    .pkt_y_o     (pkt_y),
    .pkt_src_x_o (pkt_src_x),
    .pkt_src_y_o (pkt_src_y),
    .v_o         (v),
    .ready_i     (ready),
    .my_x_i      (my_x),
    .my_y_i      (my_y),
    .img_rd_o    (img_rd),
    .img_addr_o  (img_addr),
    .img_data_i  (img_data),
    .done_o      (done)
  );

  tb_checker #(
    .tg_org_x_p       (tg_org_x),
    .tg_org_y_p       (tg_org_y),
    .tg_dim_x_p       (tg_dim_x),
    .tg_dim_y_p       (tg_dim_y),
    .icache_entries_p (icache_n),
    .dmem_words_p     (dmem_n),
    .dmem_base_word_p (dmem_base),
    .img_dmem_word_p  (img_dmem),
    .img_words_p      (img_words)
  ) checker_inst (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .pkt_addr_i  (pkt_addr),
    .pkt_data_i  (pkt_data),
    .pkt_x_i     (pkt_x),
    .pkt_y_i     (pkt_y),
    .pkt_src_x_i (pkt_src_x),
    .pkt_src_y_i (pkt_src_y),
    .v_i         (v),
    .ready_i     (ready),
    .done_i      (done),
    .img_rd_i    (img_rd),
    .my_x_i      (my_x),
    .my_y_i      (my_y),
    .image_i     (image_mem),
    .finished_o  (chk_finished),
    .errors_o    (chk_errors)
  );

  initial begin : main
    int   cycles;
    int   assert_fails;
    logic timed_out;
    rst_n    = 1'b0;
    ready    = 1'b0;
    img_data = '0;
    my_x     = 4'd5;   // loader sits outside the tile group
    my_y     = 4'd3;
    rng      = 32'd98254;
    for (int i = 0; i < img_words; i++) begin
      rng          = lcg_next(rng);
      image_mem[i] = rng;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n  = 1'b1;
    cycles = 0;
    while (!chk_finished && cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    timed_out    = !chk_finished;
    assert_fails = spmd_loader_inst.packet_former_inst.loader_chk_inst.assert_fails;
    if (timed_out) begin
      $display("run stopped: loader did not finish within %0d cycles", cycles);
    end
    if (assert_fails != 0) begin
      $display("%0d handshake assertion failures", assert_fails);
    end
    if (!timed_out && chk_errors == 0 && assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
common/spmd_pkg.sv
common/loader_pkg.sv
common/load_req_if.sv
common/load_word_if.sv
loader/spmd_phase_ctrl.sv
loader/image_fetch.sv
loader/packet_former.sv
verilog/spmd_loader.sv
testbench/loader_chk.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the loader testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -f files.f --Mdir "$build_dir" -o tb_top_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/tb_top_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the verdict is the pass line in the log
if grep -qx "TEST OK" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1
